//--- logic/execPkg.sv
package execPkg;

	// --------------------
	// Data widths
	// --------------------

	// Operand and result word
	typedef logic [63:0] word_t;

	// Register number, x0 reads as zero
	typedef logic [4:0] regIdx_t;

	// --------------------
	// Operations
	// --------------------

	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_AND   = 4'd2,
		OP_OR    = 4'd3,
		OP_XOR   = 4'd4,
		OP_SLL   = 4'd5,
		OP_SRL   = 4'd6,
		OP_SRA   = 4'd7,
		OP_SLT   = 4'd8,
		OP_SLTU  = 4'd9,
		OP_LINK  = 4'd10,
		OP_MUL   = 4'd11,
		OP_MULHU = 4'd12,
		OP_DIVU  = 4'd13,
		OP_REMU  = 4'd14
	} execOp_t;

	// Operation code as seen by the multiply/divide unit
	typedef enum logic [1:0] {
		MD_MUL   = 2'd0,
		MD_MULHU = 2'd1,
		MD_DIVU  = 2'd2,
		MD_REMU  = 2'd3
	} mulDivOp_t;

	// --------------------
	// State machines
	// --------------------

	typedef enum logic {
		CTRL_IDLE,
		CTRL_WAIT
	} ctrlState_t;

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_RUN,
		MD_DONE
	} mdState_t;

endpackage

//--- logic/mulDivIntf.sv
`timescale 1ns/100ps

// Request and response lines around the iterative multiply/divide unit
interface mulDivIntf;

	logic              start;
	execPkg::mulDivOp_t op;
	execPkg::word_t    a;
	execPkg::word_t    b;
	execPkg::word_t    result;
	logic              done;

	// Control issues the request and watches for completion
	modport ctrl (output start, output op, input done);

	// Operand selection supplies the operands
	modport src (output a, output b);

	modport unit (input start, input op, input a, input b, output result, output done);

	// Result stage collects the answer
	modport sink (input result, input done);

endinterface

//--- logic/operandSelect.sv
`timescale 1ns/100ps

module operandSelect (
	input  execPkg::word_t   inPc,
	input  execPkg::execOp_t inOp,
	input  execPkg::word_t   inRs1Data,
	input  execPkg::word_t   inRs2Data,
	input  execPkg::word_t   inImm,
	input  logic             inUseImm,
	input  logic             fwdA,
	input  logic             fwdB,
	input  execPkg::word_t   regResult,
	output execPkg::word_t   a,
	output execPkg::word_t   b,
	output execPkg::word_t   storeData,
	mulDivIntf.src           md
);

	execPkg::word_t rs1Value;
	execPkg::word_t rs2Value;

	// --------------------
	// Forwarding from the output register
	// --------------------
	assign rs1Value = fwdA ? regResult : inRs1Data;
	assign rs2Value = fwdB ? regResult : inRs2Data;

	// Link takes the PC as its first source
	assign a = (inOp == execPkg::OP_LINK) ? inPc : rs1Value;
	assign b = inUseImm ? inImm : rs2Value;

	// Store data always comes from rs2, never the immediate
	assign storeData = rs2Value;

	// Same operands feed the iterative unit
	assign md.a = a;
	assign md.b = b;

endmodule

//--- logic/alu.sv
`timescale 1ns/100ps

module alu (
	input  execPkg::execOp_t op,
	input  execPkg::word_t   a,
	input  execPkg::word_t   b,
	input  execPkg::word_t   pc,
	output execPkg::word_t   y
);

	logic [5:0] shamt;
	logic       lessSigned;
	logic       lessUnsigned;

	// Only the low six bits count for 64-bit shifts
	assign shamt = b[5:0];

	assign lessSigned   = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		unique case (op)
			execPkg::OP_ADD: begin
				y = a + b;
			end
			execPkg::OP_SUB: begin
				y = a - b;
			end
			execPkg::OP_AND: begin
				y = a & b;
			end
			execPkg::OP_OR: begin
				y = a | b;
			end
			execPkg::OP_XOR: begin
				y = a ^ b;
			end
			execPkg::OP_SLL: begin
				y = a << shamt;
			end
			execPkg::OP_SRL: begin
				y = a >> shamt;
			end
			execPkg::OP_SRA: begin
				y = $signed(a) >>> shamt;
			end
			execPkg::OP_SLT: begin
				y = {63'd0, lessSigned};
			end
			execPkg::OP_SLTU: begin
				y = {63'd0, lessUnsigned};
			end
			// Return address of the link
			execPkg::OP_LINK: begin
				y = pc + 64'd4;
			end
			default: begin
				// Multiply/divide results come from the unit
				y = '0;
			end
		endcase
	end

endmodule

//--- logic/mulDivUnit.sv
`timescale 1ns/100ps

module mulDivUnit (
	input logic clk,
	input logic reset,
	mulDivIntf.unit md
);

	execPkg::mdState_t  state;
	execPkg::mulDivOp_t opReg;
	execPkg::word_t     bReg;
	execPkg::word_t     hi;
	execPkg::word_t     lo;
	logic [5:0]         count;

	logic               isMul;
	logic [64:0]        mulSum;
	logic [64:0]        divShift;
	logic [64:0]        divDiff;
	logic               divFits;
	execPkg::word_t     nextHi;
	execPkg::word_t     nextLo;

	assign isMul = (opReg == execPkg::MD_MUL) || (opReg == execPkg::MD_MULHU);

	// --------------------
	// One iteration step
	// --------------------
	always_comb begin
		// Shift-add: hi accumulates, lo holds the multiplier bits
		mulSum = {1'b0, hi} + (lo[0] ? {1'b0, bReg} : 65'd0);

		// Restoring divide: hi is the remainder, lo the quotient
		divShift = {hi, lo[63]};
		divFits  = divShift >= {1'b0, bReg};
		divDiff  = divShift - {1'b0, bReg};

		if (isMul) begin
			nextHi = mulSum[64:1];
			nextLo = {mulSum[0], lo[63:1]};
		end else if (divFits) begin
			nextHi = divDiff[63:0];
			nextLo = {lo[62:0], 1'b1};
		end else begin
			nextHi = divShift[63:0];
			nextLo = {lo[62:0], 1'b0};
		end
	end

	// --------------------
	// Sequencing
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= execPkg::MD_IDLE;
			count <= '0;
		end else begin
			unique case (state)
				execPkg::MD_IDLE: begin
					if (md.start) begin
						state <= execPkg::MD_RUN;
						count <= '0;
					end
				end
				execPkg::MD_RUN: begin
					count <= count + 6'd1;
					// 64th bit done
					if (count == 6'd63) begin
						state <= execPkg::MD_DONE;
					end
				end
				default: begin
					state <= execPkg::MD_IDLE;
				end
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		if (state == execPkg::MD_IDLE && md.start) begin
			opReg <= md.op;
			bReg  <= md.b;
			hi    <= '0;
			lo    <= md.a;
		end else if (state == execPkg::MD_RUN) begin
			hi <= nextHi;
			lo <= nextLo;
		end
	end

	assign md.done = (state == execPkg::MD_DONE);

	always_comb begin
		unique case (opReg)
			execPkg::MD_MUL:   md.result = lo;
			execPkg::MD_MULHU: md.result = hi;
			execPkg::MD_DIVU:  md.result = lo;
			default:           md.result = hi;
		endcase
	end

endmodule

//--- logic/execControl.sv
`timescale 1ns/100ps

module execControl (
	input  logic             clk,
	input  logic             reset,
	input  logic             inValid,
	output logic             inReady,
	input  execPkg::execOp_t inOp,
	input  execPkg::regIdx_t inRs1,
	input  execPkg::regIdx_t inRs2,
	input  logic             regValid,
	input  execPkg::regIdx_t regRd,
	output logic             fwdA,
	output logic             fwdB,
	output logic             accept,
	output logic             resultFromUnit,
	mulDivIntf.ctrl          md
);

	execPkg::ctrlState_t state;
	logic                isMulDiv;

	assign isMulDiv = (inOp == execPkg::OP_MUL) || (inOp == execPkg::OP_MULHU) ||
		(inOp == execPkg::OP_DIVU) || (inOp == execPkg::OP_REMU);

	// --------------------
	// Handshake
	// --------------------
	assign inReady        = (state == execPkg::CTRL_IDLE);
	assign accept         = inValid && inReady;
	assign resultFromUnit = isMulDiv;
	assign md.start       = accept && isMulDiv;

	always_comb begin
		unique case (inOp)
			execPkg::OP_MULHU: md.op = execPkg::MD_MULHU;
			execPkg::OP_DIVU:  md.op = execPkg::MD_DIVU;
			execPkg::OP_REMU:  md.op = execPkg::MD_REMU;
			default:           md.op = execPkg::MD_MUL;
		endcase
	end

	// Forward the last result unless the source is x0
	assign fwdA = regValid && (regRd == inRs1) && (inRs1 != 5'd0);
	assign fwdB = regValid && (regRd == inRs2) && (inRs2 != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= execPkg::CTRL_IDLE;
		end else begin
			unique case (state)
				execPkg::CTRL_IDLE: begin
					if (md.start) begin
						state <= execPkg::CTRL_WAIT;
					end
				end
				default: begin
					if (md.done) begin
						state <= execPkg::CTRL_IDLE;
					end
				end
			endcase
		end
	end

endmodule

//--- logic/resultStage.sv
`timescale 1ns/100ps

module resultStage (
	input  logic             clk,
	input  logic             reset,
	input  logic             accept,
	input  logic             resultFromUnit,
	input  execPkg::word_t   inPc,
	input  execPkg::regIdx_t inRd,
	input  execPkg::word_t   aluY,
	input  execPkg::word_t   storeData,
	mulDivIntf.sink          md,
	output logic             outValid,
	output execPkg::word_t   outPc,
	output execPkg::regIdx_t outRd,
	output execPkg::word_t   outResult,
	output execPkg::word_t   outStoreData
);

	execPkg::word_t   pendPc;
	execPkg::regIdx_t pendRd;
	execPkg::word_t   pendStore;
	logic             publishAlu;

	assign publishAlu = accept && !resultFromUnit;

	// --------------------
	// Pending multiply/divide instruction
	// --------------------
	always_ff @(posedge clk) begin
		if (accept && resultFromUnit) begin
			pendPc    <= inPc;
			pendRd    <= inRd;
			pendStore <= storeData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
		end else begin
			outValid <= publishAlu || md.done;
		end
	end

	// Output register, also the forwarding source
	always_ff @(posedge clk) begin
		if (publishAlu) begin
			outPc        <= inPc;
			outRd        <= inRd;
			outResult    <= aluY;
			outStoreData <= storeData;
		end else if (md.done) begin
			outPc        <= pendPc;
			outRd        <= pendRd;
			outResult    <= md.result;
			outStoreData <= pendStore;
		end
	end

endmodule

//--- logic/execStage.sv
`timescale 1ns/100ps

module execStage (
	input  logic             clk,
	input  logic             reset,
	input  logic             inValid,
	output logic             inReady,
	input  execPkg::word_t   inPc,
	input  execPkg::execOp_t inOp,
	input  execPkg::regIdx_t inRs1,
	input  execPkg::regIdx_t inRs2,
	input  execPkg::regIdx_t inRd,
	input  execPkg::word_t   inRs1Data,
	input  execPkg::word_t   inRs2Data,
	input  execPkg::word_t   inImm,
	input  logic             inUseImm,
	output logic             outValid,
	output execPkg::word_t   outPc,
	output execPkg::regIdx_t outRd,
	output execPkg::word_t   outResult,
	output execPkg::word_t   outStoreData
);

	logic           fwdA;
	logic           fwdB;
	logic           accept;
	logic           resultFromUnit;
	execPkg::word_t a;
	execPkg::word_t b;
	execPkg::word_t storeData;
	execPkg::word_t aluY;

	mulDivIntf md ();

	// --------------------
	// Control and operands
	// --------------------
	execControl control (
		.clk, .reset,
		.inValid, .inReady, .inOp, .inRs1, .inRs2,
		.regValid(outValid),
		.regRd(outRd),
		.fwdA, .fwdB, .accept, .resultFromUnit,
		.md(md.ctrl)
	);

	operandSelect operands (
		.inPc, .inOp, .inRs1Data, .inRs2Data, .inImm, .inUseImm,
		.fwdA, .fwdB,
		.regResult(outResult),
		.a, .b, .storeData,
		.md(md.src)
	);

	// --------------------
	// Execution units
	// --------------------
	alu aluUnit (
		.op(inOp),
		.a, .b,
		.pc(inPc),
		.y(aluY)
	);

	mulDivUnit mulDiv (
		.clk, .reset,
		.md(md.unit)
	);

	resultStage results (
		.clk, .reset,
		.accept, .resultFromUnit,
		.inPc, .inRd, .aluY, .storeData,
		.md(md.sink),
		.outValid, .outPc, .outRd, .outResult, .outStoreData
	);

endmodule

//--- tests/execStageTb.sv
`timescale 1ns/100ps

module execStageTb;

	localparam int NUM_INSTR   = 400;
	localparam int CYCLE_LIMIT = NUM_INSTR * 70;
	// Edges from acceptance until the unit result is registered
	localparam int UNIT_CYCLES = 65;
	localparam execPkg::word_t SIGN_BIT = 64'h8000_0000_0000_0000;

	typedef struct packed {
		execPkg::word_t   pc;
		execPkg::regIdx_t rd;
		execPkg::word_t   result;
		execPkg::word_t   store;
		int               due;
	} expect_t;

	logic             clk;
	logic             reset;
	logic             inValid;
	logic             inReady;
	execPkg::word_t   inPc;
	execPkg::execOp_t inOp;
	execPkg::regIdx_t inRs1;
	execPkg::regIdx_t inRs2;
	execPkg::regIdx_t inRd;
	execPkg::word_t   inRs1Data;
	execPkg::word_t   inRs2Data;
	execPkg::word_t   inImm;
	logic             inUseImm;
	logic             outValid;
	execPkg::word_t   outPc;
	execPkg::regIdx_t outRd;
	execPkg::word_t   outResult;
	execPkg::word_t   outStoreData;

	integer           seed = 32'h27d2_d824;
	// Committed registers one result behind the DUT
	execPkg::word_t   regModel [32];
	// Architectural registers updated at acceptance
	execPkg::word_t   archRegs [32];
	expect_t          expQ [$];
	expect_t          item;
	expect_t          head;
	execPkg::word_t   opA;
	execPkg::word_t   opB;
	logic             expValid;
	logic             expReady;
	logic             taken = 1'b0;
	execPkg::regIdx_t lastRd = 5'd0;
	int               cycle = 0;
	int               unitAccept = -1000;
	int               acceptedCount = 0;
	int               issuedCount = 0;

	execStage dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------
	// Random helpers
	// --------------------
	function automatic int unsigned randBelow(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic execPkg::regIdx_t pickReg();
		// Mostly a few low registers so dependences are common
		if (randBelow(4) == 0) begin
			return 5'(randBelow(32));
		end
		return 5'(randBelow(8));
	endfunction

	function automatic execPkg::word_t pickValue();
		case (randBelow(8))
			0: return 64'd0;
			1: return 64'hffff_ffff_ffff_ffff;
			2: return SIGN_BIT;
			3: return 64'(randBelow(80));
			4: return 64'h7fff_ffff_ffff_ffff;
			default: return {$random(seed), $random(seed)};
		endcase
	endfunction

	function automatic logic isMulDivOp(execPkg::execOp_t op);
		return (op == execPkg::OP_MUL) || (op == execPkg::OP_MULHU) ||
			(op == execPkg::OP_DIVU) || (op == execPkg::OP_REMU);
	endfunction

	// --------------------
	// Reference model
	// --------------------
	function automatic execPkg::word_t refResult(execPkg::execOp_t op, execPkg::word_t a,
		execPkg::word_t b, execPkg::word_t pc);
		logic [127:0]   prod;
		logic [5:0]     sh;
		execPkg::word_t signFill;
		sh       = b[5:0];
		prod     = {64'd0, a} * {64'd0, b};
		// High bits set by an arithmetic shift of a negative value
		signFill = a[63] ? ~(64'hffff_ffff_ffff_ffff >> sh) : 64'd0;
		case (op)
			execPkg::OP_ADD:   return a + b;
			execPkg::OP_SUB:   return a - b;
			execPkg::OP_AND:   return a & b;
			execPkg::OP_OR:    return a | b;
			execPkg::OP_XOR:   return a ^ b;
			execPkg::OP_SLL:   return a << sh;
			execPkg::OP_SRL:   return a >> sh;
			execPkg::OP_SRA:   return (a >> sh) | signFill;
			execPkg::OP_SLT:   return {63'd0, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)};
			execPkg::OP_SLTU:  return {63'd0, a < b};
			execPkg::OP_LINK:  return pc + 64'd4;
			execPkg::OP_MUL:   return prod[63:0];
			execPkg::OP_MULHU: return prod[127:64];
			execPkg::OP_DIVU:  return (b == 64'd0) ? 64'hffff_ffff_ffff_ffff : a / b;
			default:           return (b == 64'd0) ? a : a % b;
		endcase
	endfunction

	// --------------------
	// Compare tasks
	// --------------------
	task automatic checkWord(string name, execPkg::word_t got, execPkg::word_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic checkReg(string name, execPkg::regIdx_t got, execPkg::regIdx_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at first error");
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------
	task automatic offerInstruction();
		inValid  = 1'b1;
		inOp     = execPkg::execOp_t'(4'(randBelow(15)));
		inPc     = {$random(seed), $random(seed)} & ~64'h3;
		inRd     = pickReg();
		inRs1    = (randBelow(2) == 0) ? lastRd : pickReg();
		inRs2    = (randBelow(2) == 0) ? lastRd : pickReg();
		inImm    = pickValue();
		inUseImm = 1'(randBelow(2));
		lastRd   = inRd;
	endtask

	initial begin
		reset     = 1'b1;
		inValid   = 1'b0;
		inPc      = '0;
		inOp      = execPkg::OP_ADD;
		inRs1     = '0;
		inRs2     = '0;
		inRd      = '0;
		inRs1Data = '0;
		inRs2Data = '0;
		inImm     = '0;
		inUseImm  = 1'b0;
		regModel[0] = 64'd0;
		archRegs[0] = 64'd0;
		for (int i = 1; i < 32; i++) begin
			regModel[i] = pickValue();
			archRegs[i] = regModel[i];
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// Idle cycles before the first instruction
		repeat (3) @(negedge clk);
		while (acceptedCount < NUM_INSTR) begin
			@(negedge clk);
			if (taken || !inValid) begin
				taken = 1'b0;
				if (issuedCount < NUM_INSTR && randBelow(8) != 0) begin
					offerInstruction();
					issuedCount++;
				end else begin
					inValid = 1'b0;
				end
			end
			// Data one result stale so the DUT must forward
			inRs1Data = regModel[inRs1];
			inRs2Data = regModel[inRs2];
		end
		// Longest drain is one unit operation plus the output register
		repeat (UNIT_CYCLES + 4) @(negedge clk);
		if (expQ.size() != 0) begin
			$display("%0d expected results never appeared", expQ.size());
			$display("*** TEST FAILED ***");
			$fatal(1, "results lost");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	// Record each accepted instruction with its expected outcome
	always @(posedge clk) begin
		if (!reset && inValid && inReady) begin
			opA         = (inOp == execPkg::OP_LINK) ? inPc : archRegs[inRs1];
			opB         = inUseImm ? inImm : archRegs[inRs2];
			item.pc     = inPc;
			item.rd     = inRd;
			item.result = refResult(inOp, opA, opB, inPc);
			item.store  = archRegs[inRs2];
			item.due    = isMulDivOp(inOp) ? cycle + UNIT_CYCLES + 1 : cycle + 1;
			expQ.push_back(item);
			if (inRd != 5'd0) begin
				archRegs[inRd] = item.result;
			end
			if (isMulDivOp(inOp)) begin
				unitAccept = cycle;
			end
			acceptedCount++;
			taken = 1'b1;
		end
	end

	// Output and handshake checks
	always @(posedge clk) begin
		if (!reset) begin
			expValid = (expQ.size() != 0) && (expQ[0].due == cycle);
			expReady = !((cycle > unitAccept) && (cycle <= unitAccept + UNIT_CYCLES));
			checkFlag("inReady", inReady, expReady);
			checkFlag("outValid", outValid, expValid);
			if (expValid) begin
				head = expQ.pop_front();
				checkWord("outPc", outPc, head.pc);
				checkReg("outRd", outRd, head.rd);
				checkWord("outResult", outResult, head.result);
				checkWord("outStoreData", outStoreData, head.store);
				if (outRd != 5'd0) begin
					regModel[outRd] = outResult;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the instruction stream did not finish", cycle);
			$display("*** TEST FAILED ***");
			$fatal(1, "cycle limit reached");
		end
	end

endmodule

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --timescale 1ns/100ps -f vlog.f \
		--top-module execStageTb -Mdir obj_dir
	./obj_dir/VexecStageTb

clean:
	rm -rf obj_dir

//--- vlog.f
logic/execPkg.sv
logic/mulDivIntf.sv
logic/operandSelect.sv
logic/alu.sv
logic/mulDivUnit.sv
logic/execControl.sv
logic/resultStage.sv
logic/execStage.sv
tests/execStageTb.sv
